/* sources.f */
src/rv_isa_pkg.sv
src/core_pkg.sv
src/regfile.sv
src/decoder.sv
src/execute_unit.sv
src/lsu.sv
src/core_ctrl.sv
src/secv_core.sv
testbench/secv_core_checker.sv
testbench/tb_secv_core.sv

/* src/core_ctrl.sv */
// Main control FSM with fetch and write-back
module core_ctrl import rv_isa_pkg::*, core_pkg::*; #(
    parameter int IADR_WIDTH = 8
) (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  inst_t                 imem_dat_i,
    input  logic                  imem_ack_i,
    input  pc_sel_t               pc_sel_i,
    input  rd_sel_t               rd_sel_i,
    input  logic                  is_mem_i,
    input  logic                  take_i,
    input  xlen_word_t            target_i,
    input  xlen_word_t            alu_res_i,
    input  xlen_word_t            load_dat_i,
    input  logic                  mem_done_i,
    output logic                  imem_cyc_o,
    output logic                  imem_stb_o,
    output logic [IADR_WIDTH-1:0] imem_adr_o,
    output inst_t                 ir_o,
    output xlen_word_t            pc_o,
    output logic                  mem_start_o,
    output xlen_word_t            rd_dat_o,
    output logic                  rd_we_o
);
    state_t     state, state_next;
    xlen_word_t pc, pc_next, pc_inc;
    inst_t      ir;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state <= ST_IDLE;
            pc    <= '0;
            ir    <= INST_NOP;
        end else begin
            state <= state_next;
            if (state == ST_FETCH && imem_ack_i) begin
                ir <= imem_dat_i;
            end
            if (state == ST_WB) begin
                pc <= pc_next;
            end
        end
    end

    // Sequencing, FETCH and MEM wait on their ack
    always_comb begin
        unique case (state)
            ST_IDLE:    state_next = ST_FETCH;
            ST_FETCH:   state_next = imem_ack_i ? ST_DECODE : ST_FETCH;
            ST_DECODE:  state_next = ST_EXECUTE;
            ST_EXECUTE: state_next = is_mem_i ? ST_MEM : ST_WB;
            ST_MEM:     state_next = mem_done_i ? ST_WB : ST_MEM;
            default:    state_next = ST_FETCH;
        endcase
    end

    // Instruction bus request held through FETCH
    assign imem_cyc_o = (state == ST_FETCH);
    assign imem_stb_o = (state == ST_FETCH);
    assign imem_adr_o = pc[IADR_WIDTH-1:0];

    // One-cycle kick for the LSU
    assign mem_start_o = (state == ST_EXECUTE) && is_mem_i;

    // Next PC, JALR target with bit 0 cleared
    assign pc_inc = pc + 32'd4;
    always_comb begin
        case (pc_sel_i)
            PC_BRANCH: pc_next = take_i ? target_i : pc_inc;
            PC_JALR:   pc_next = {alu_res_i[31:1], 1'b0};
            default:   pc_next = pc_inc;
        endcase
    end

    // Write-back value
    always_comb begin
        case (rd_sel_i)
            RD_LOAD: rd_dat_o = load_dat_i;
            RD_PC4:  rd_dat_o = pc_inc;
            default: rd_dat_o = alu_res_i;
        endcase
    end

    assign rd_we_o = (state == ST_WB) && (rd_sel_i != RD_NONE);
    assign ir_o    = ir;
    assign pc_o    = pc;
endmodule

/* src/core_pkg.sv */
// Core control types
package core_pkg;

    // Main FSM states
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_FETCH,
        ST_DECODE,
        ST_EXECUTE,
        ST_MEM,
        ST_WB
    } state_t;

    // ALU operations
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_t;

    // Operand and write-back selects
    typedef enum logic [1:0] {SRC1_ZERO, SRC1_RS1, SRC1_PC} src1_sel_t;
    typedef enum logic {SRC2_RS2, SRC2_IMM} src2_sel_t;
    typedef enum logic [1:0] {RD_NONE, RD_ALU, RD_LOAD, RD_PC4} rd_sel_t;

    // Next PC source
    typedef enum logic [1:0] {PC_INC, PC_BRANCH, PC_JALR} pc_sel_t;

    // Condition code for JAL, a branch encoding RV32I leaves unused
    localparam logic [2:0] BR_ALWAYS = 3'b010;
endpackage

/* src/decoder.sv */
// Instruction decoder
module decoder import rv_isa_pkg::*, core_pkg::*; (
    input  inst_t      ir_i,
    output reg_adr_t   rs1_adr_o,
    output reg_adr_t   rs2_adr_o,
    output reg_adr_t   rd_adr_o,
    output funct3_t    funct3_o,
    output xlen_word_t imm_o,
    output alu_op_t    alu_op_o,
    output src1_sel_t  src1_sel_o,
    output src2_sel_t  src2_sel_o,
    output rd_sel_t    rd_sel_o,
    output pc_sel_t    pc_sel_o,
    output logic       is_branch_o,
    output logic       is_mem_o,
    output logic       mem_we_o
);
    opcode_t    opcode;
    funct3_t    funct3;
    xlen_word_t imm_i, imm_s, imm_b, imm_u, imm_j;
    alu_op_t    alu_fn;
    rd_sel_t    rd_sel;

    // Instruction fields
    assign opcode    = opcode_t'(ir_i[6:0]);
    assign funct3    = ir_i[14:12];
    assign rs1_adr_o = ir_i[19:15];
    assign rs2_adr_o = ir_i[24:20];
    assign rd_adr_o  = ir_i[11:7];

    // Sign-extended immediate formats
    assign imm_i = {{20{ir_i[31]}}, ir_i[31:20]};
    assign imm_s = {{20{ir_i[31]}}, ir_i[31:25], ir_i[11:7]};
    assign imm_b = {{19{ir_i[31]}}, ir_i[31], ir_i[7], ir_i[30:25], ir_i[11:8], 1'b0};
    assign imm_u = {ir_i[31:12], 12'b0};
    assign imm_j = {{11{ir_i[31]}}, ir_i[31], ir_i[19:12], ir_i[20], ir_i[30:21], 1'b0};

    // ALU function for OP and OP-IMM
    always_comb begin
        unique case (funct3)
            // SUB only exists in register form
            F3_ADD_SUB: alu_fn = (opcode == OPC_OP && ir_i[30]) ? ALU_SUB : ALU_ADD;
            F3_SLL:     alu_fn = ALU_SLL;
            F3_SLT:     alu_fn = ALU_SLT;
            F3_SLTU:    alu_fn = ALU_SLTU;
            F3_XOR:     alu_fn = ALU_XOR;
            F3_SRL_SRA: alu_fn = ir_i[30] ? ALU_SRA : ALU_SRL;
            F3_OR:      alu_fn = ALU_OR;
            F3_AND:     alu_fn = ALU_AND;
        endcase
    end

    // Control selects per opcode
    always_comb begin
        // No-op defaults, also for unknown opcodes
        imm_o       = imm_i;
        funct3_o    = funct3;
        alu_op_o    = ALU_ADD;
        src1_sel_o  = SRC1_ZERO;
        src2_sel_o  = SRC2_IMM;
        rd_sel      = RD_NONE;
        pc_sel_o    = PC_INC;
        is_branch_o = 1'b0;
        is_mem_o    = 1'b0;
        mem_we_o    = 1'b0;
        case (opcode)
            OPC_OP: begin
                alu_op_o = alu_fn;
                src1_sel_o = SRC1_RS1;
                src2_sel_o = SRC2_RS2;
                rd_sel = RD_ALU;
            end
            OPC_OP_IMM: begin
                alu_op_o = alu_fn;
                src1_sel_o = SRC1_RS1;
                rd_sel = RD_ALU;
            end
            OPC_LUI: begin
                imm_o = imm_u;
                rd_sel = RD_ALU;
            end
            OPC_AUIPC: begin
                imm_o = imm_u;
                src1_sel_o = SRC1_PC;
                rd_sel = RD_ALU;
            end
            OPC_JAL: begin
                // Always-taken branch with link
                imm_o = imm_j;
                funct3_o = BR_ALWAYS;
                is_branch_o = 1'b1;
                pc_sel_o = PC_BRANCH;
                rd_sel = RD_PC4;
            end
            OPC_JALR: begin
                src1_sel_o = SRC1_RS1;
                pc_sel_o = PC_JALR;
                rd_sel = RD_PC4;
            end
            OPC_BRANCH: begin
                imm_o = imm_b;
                is_branch_o = 1'b1;
                pc_sel_o = PC_BRANCH;
            end
            OPC_LOAD: begin
                src1_sel_o = SRC1_RS1;
                is_mem_o = 1'b1;
                rd_sel = RD_LOAD;
            end
            OPC_STORE: begin
                imm_o = imm_s;
                src1_sel_o = SRC1_RS1;
                is_mem_o = 1'b1;
                mem_we_o = 1'b1;
            end
            default: ;
        endcase
    end

    // Writes to x0 are dropped here
    assign rd_sel_o = (rd_adr_o == '0) ? RD_NONE : rd_sel;
endmodule

/* src/execute_unit.sv */
// Operand select, ALU and branch compare
module execute_unit import rv_isa_pkg::*, core_pkg::*; (
    input  xlen_word_t rs1_dat_i,
    input  xlen_word_t rs2_dat_i,
    input  xlen_word_t pc_i,
    input  xlen_word_t imm_i,
    input  alu_op_t    alu_op_i,
    input  src1_sel_t  src1_sel_i,
    input  src2_sel_t  src2_sel_i,
    input  logic       is_branch_i,
    input  funct3_t    funct3_i,
    output xlen_word_t res_o,
    output xlen_word_t target_o,
    output logic       take_o
);
    xlen_word_t src1, src2;
    logic [4:0] shamt;
    logic       cond;

    // Operand 1, zero for LUI and no-ops
    always_comb begin
        case (src1_sel_i)
            SRC1_RS1: src1 = rs1_dat_i;
            SRC1_PC:  src1 = pc_i;
            default:  src1 = '0;
        endcase
    end

    assign src2  = (src2_sel_i == SRC2_IMM) ? imm_i : rs2_dat_i;
    assign shamt = src2[4:0];

    always_comb begin
        unique case (alu_op_i)
            ALU_ADD:  res_o = src1 + src2;
            ALU_SUB:  res_o = src1 - src2;
            ALU_SLL:  res_o = src1 << shamt;
            ALU_SLT:  res_o = {31'b0, $signed(src1) < $signed(src2)};
            ALU_SLTU: res_o = {31'b0, src1 < src2};
            ALU_XOR:  res_o = src1 ^ src2;
            ALU_SRL:  res_o = src1 >> shamt;
            ALU_SRA:  res_o = $signed(src1) >>> shamt;
            ALU_OR:   res_o = src1 | src2;
            default:  res_o = src1 & src2;
        endcase
    end

    // Branch and JAL destination
    assign target_o = pc_i + imm_i;

    // Branch condition on the raw register values
    always_comb begin
        case (funct3_i)
            F3_BEQ:    cond = rs1_dat_i == rs2_dat_i;
            F3_BNE:    cond = rs1_dat_i != rs2_dat_i;
            F3_BLT:    cond = $signed(rs1_dat_i) < $signed(rs2_dat_i);
            F3_BGE:    cond = $signed(rs1_dat_i) >= $signed(rs2_dat_i);
            F3_BLTU:   cond = rs1_dat_i < rs2_dat_i;
            F3_BGEU:   cond = rs1_dat_i >= rs2_dat_i;
            BR_ALWAYS: cond = 1'b1;
            default:   cond = 1'b0;
        endcase
    end

    assign take_o = is_branch_i & cond;
endmodule

/* src/lsu.sv */
// Data bus master for word loads and stores
module lsu import rv_isa_pkg::*; #(
    parameter int DADR_WIDTH = 8
) (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  start_i,
    input  logic                  we_i,
    input  xlen_word_t            adr_i,
    input  xlen_word_t            wdat_i,
    input  xlen_word_t            dmem_dat_i,
    input  logic                  dmem_ack_i,
    output logic                  done_o,
    output xlen_word_t            rdat_o,
    output logic                  dmem_cyc_o,
    output logic                  dmem_stb_o,
    output logic                  dmem_we_o,
    output logic [DADR_WIDTH-1:0] dmem_adr_o,
    output xlen_word_t            dmem_dat_o
);
    // Bus cycle control
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            dmem_cyc_o <= 1'b0;
            dmem_we_o  <= 1'b0;
        end else if (start_i) begin
            dmem_cyc_o <= 1'b1;
            dmem_we_o  <= we_i;
        end else if (dmem_cyc_o && dmem_ack_i) begin
            dmem_cyc_o <= 1'b0;
            dmem_we_o  <= 1'b0;
        end
    end

    // Request payload, held for the whole cycle
    always_ff @(posedge clk_i) begin
        if (start_i) begin
            dmem_adr_o <= adr_i[DADR_WIDTH-1:0];
            dmem_dat_o <= wdat_i;
        end
        // Load data captured in the ack cycle
        if (dmem_cyc_o && dmem_ack_i && !dmem_we_o) begin
            rdat_o <= dmem_dat_i;
        end
    end

    // Single request per cycle, stb follows cyc
    assign dmem_stb_o = dmem_cyc_o;
    assign done_o     = dmem_cyc_o & dmem_ack_i;
endmodule

/* src/regfile.sv */
// General purpose register file
module regfile import rv_isa_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_i,
    input  reg_adr_t   rs1_adr_i,
    input  reg_adr_t   rs2_adr_i,
    input  reg_adr_t   rd_adr_i,
    input  xlen_word_t rd_dat_i,
    input  logic       rd_we_i,
    output xlen_word_t rs1_dat_o,
    output xlen_word_t rs2_dat_o
);
    // x1 to x31, x0 has no storage
    xlen_word_t regs [1:31];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_we_i && rd_adr_i != '0) begin
            regs[rd_adr_i] <= rd_dat_i;
        end
    end

    // Asynchronous read ports
    assign rs1_dat_o = (rs1_adr_i == '0) ? '0 : regs[rs1_adr_i];
    assign rs2_dat_o = (rs2_adr_i == '0) ? '0 : regs[rs2_adr_i];
endmodule

/* src/rv_isa_pkg.sv */
// RV32I instruction set encodings
package rv_isa_pkg;

    // Basic machine widths
    typedef logic [31:0] xlen_word_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_adr_t;
    typedef logic [2:0]  funct3_t;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_OP_IMM = 7'b0010011,
        OPC_AUIPC  = 7'b0010111,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JALR   = 7'b1100111,
        OPC_JAL    = 7'b1101111
    } opcode_t;

    // Arithmetic and logic function codes
    localparam funct3_t F3_ADD_SUB = 3'b000;
    localparam funct3_t F3_SLL     = 3'b001;
    localparam funct3_t F3_SLT     = 3'b010;
    localparam funct3_t F3_SLTU    = 3'b011;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_SRL_SRA = 3'b101;
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;

    // Branch conditions
    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    // ADDI x0, x0, 0
    localparam inst_t INST_NOP = 32'h0000_0013;
endpackage

/* src/secv_core.sv */
// Multi-cycle RV32I core
module secv_core import rv_isa_pkg::*, core_pkg::*; #(
    parameter int IADR_WIDTH = 8,
    parameter int DADR_WIDTH = 8
) (
    input  logic                  clk_i,
    input  logic                  rst_i,
    // Instruction bus
    output logic                  imem_cyc_o,
    output logic                  imem_stb_o,
    output logic [IADR_WIDTH-1:0] imem_adr_o,
    input  xlen_word_t            imem_dat_i,
    input  logic                  imem_ack_i,
    // Data bus
    output logic                  dmem_cyc_o,
    output logic                  dmem_stb_o,
    output logic                  dmem_we_o,
    output logic [DADR_WIDTH-1:0] dmem_adr_o,
    output xlen_word_t            dmem_dat_o,
    input  xlen_word_t            dmem_dat_i,
    input  logic                  dmem_ack_i
);
    inst_t      ir;
    xlen_word_t pc, imm, rs1_dat, rs2_dat, rd_dat, alu_res, target, load_dat;
    reg_adr_t   rs1_adr, rs2_adr, rd_adr;
    funct3_t    funct3;
    alu_op_t    alu_op;
    src1_sel_t  src1_sel;
    src2_sel_t  src2_sel;
    rd_sel_t    rd_sel;
    pc_sel_t    pc_sel;
    logic       is_branch, is_mem, mem_we, take, rd_we, mem_start, mem_done;

    core_ctrl #(.IADR_WIDTH(IADR_WIDTH)) ctrl0 (
        .clk_i(clk_i), .rst_i(rst_i),
        .imem_dat_i(imem_dat_i), .imem_ack_i(imem_ack_i),
        .pc_sel_i(pc_sel), .rd_sel_i(rd_sel), .is_mem_i(is_mem),
        .take_i(take), .target_i(target), .alu_res_i(alu_res),
        .load_dat_i(load_dat), .mem_done_i(mem_done),
        .imem_cyc_o(imem_cyc_o), .imem_stb_o(imem_stb_o), .imem_adr_o(imem_adr_o),
        .ir_o(ir), .pc_o(pc), .mem_start_o(mem_start),
        .rd_dat_o(rd_dat), .rd_we_o(rd_we)
    );

    decoder dec0 (
        .ir_i(ir),
        .rs1_adr_o(rs1_adr), .rs2_adr_o(rs2_adr), .rd_adr_o(rd_adr),
        .funct3_o(funct3), .imm_o(imm), .alu_op_o(alu_op),
        .src1_sel_o(src1_sel), .src2_sel_o(src2_sel),
        .rd_sel_o(rd_sel), .pc_sel_o(pc_sel),
        .is_branch_o(is_branch), .is_mem_o(is_mem), .mem_we_o(mem_we)
    );

    regfile gpr0 (
        .clk_i(clk_i), .rst_i(rst_i),
        .rs1_adr_i(rs1_adr), .rs2_adr_i(rs2_adr), .rd_adr_i(rd_adr),
        .rd_dat_i(rd_dat), .rd_we_i(rd_we),
        .rs1_dat_o(rs1_dat), .rs2_dat_o(rs2_dat)
    );

    execute_unit exu0 (
        .rs1_dat_i(rs1_dat), .rs2_dat_i(rs2_dat), .pc_i(pc), .imm_i(imm),
        .alu_op_i(alu_op), .src1_sel_i(src1_sel), .src2_sel_i(src2_sel),
        .is_branch_i(is_branch), .funct3_i(funct3),
        .res_o(alu_res), .target_o(target), .take_o(take)
    );

    // Store data comes straight from rs2
    lsu #(.DADR_WIDTH(DADR_WIDTH)) lsu0 (
        .clk_i(clk_i), .rst_i(rst_i),
        .start_i(mem_start), .we_i(mem_we), .adr_i(alu_res), .wdat_i(rs2_dat),
        .dmem_dat_i(dmem_dat_i), .dmem_ack_i(dmem_ack_i),
        .done_o(mem_done), .rdat_o(load_dat),
        .dmem_cyc_o(dmem_cyc_o), .dmem_stb_o(dmem_stb_o), .dmem_we_o(dmem_we_o),
        .dmem_adr_o(dmem_adr_o), .dmem_dat_o(dmem_dat_o)
    );
endmodule

/* testbench/secv_core_checker.sv */
// Bus protocol assertions
module secv_core_checker #(
    parameter int IADR_WIDTH = 8,
    parameter int DADR_WIDTH = 8
) (
    input logic                  clk_i,
    input logic                  rst_i,
    input logic                  imem_cyc_o,
    input logic                  imem_stb_o,
    input logic [IADR_WIDTH-1:0] imem_adr_o,
    input logic                  imem_ack_i,
    input logic                  dmem_cyc_o,
    input logic                  dmem_stb_o,
    input logic [DADR_WIDTH-1:0] dmem_adr_o,
    input logic                  dmem_ack_i
);
    timeunit 1ns;
    timeprecision 100ps;

    // Number of failed assertions
    int unsigned fail_cnt = 0;

    // Strobe only inside a cycle
    imem_stb_in_cyc: assert property (@(posedge clk_i) disable iff (rst_i)
        imem_stb_o |-> imem_cyc_o)
        else begin
            fail_cnt++;
            $error("imem stb high without cyc");
        end
    dmem_stb_in_cyc: assert property (@(posedge clk_i) disable iff (rst_i)
        dmem_stb_o |-> dmem_cyc_o)
        else begin
            fail_cnt++;
            $error("dmem stb high without cyc");
        end

    // Request held until ack
    imem_req_held: assert property (@(posedge clk_i) disable iff (rst_i)
        imem_stb_o && !imem_ack_i |=> imem_stb_o && $stable(imem_adr_o))
        else begin
            fail_cnt++;
            $error("imem request changed before ack");
        end
    dmem_req_held: assert property (@(posedge clk_i) disable iff (rst_i)
        dmem_stb_o && !dmem_ack_i |=> dmem_stb_o && $stable(dmem_adr_o))
        else begin
            fail_cnt++;
            $error("dmem request changed before ack");
        end

    // Fetch and data access never overlap
    bus_exclusive: assert property (@(posedge clk_i) disable iff (rst_i)
        !(imem_cyc_o && dmem_cyc_o))
        else begin
            fail_cnt++;
            $error("instruction and data bus active together");
        end
endmodule

/* testbench/tb_secv_core.sv */
// Testbench for the RV32I core
module tb_secv_core import rv_isa_pkg::*;;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int IADR_WIDTH = 8;
    localparam int DADR_WIDTH = 8;
    localparam int N_INSTR    = 2000;
    localparam int SEED       = 30;
    // Worst case stays below 12 cycles per instruction
    localparam int TIMEOUT_NS = N_INSTR * 12 * 20;

    logic                  clk_i, rst_i;
    logic                  imem_cyc_o, imem_stb_o, imem_ack_i;
    logic [IADR_WIDTH-1:0] imem_adr_o;
    xlen_word_t            imem_dat_i;
    logic                  dmem_cyc_o, dmem_stb_o, dmem_we_o, dmem_ack_i;
    logic [DADR_WIDTH-1:0] dmem_adr_o;
    xlen_word_t            dmem_dat_o, dmem_dat_i;

    // Reference model state
    xlen_word_t regs [0:31];
    xlen_word_t pc_ref, exp_adr, exp_dat;
    logic       mem_pending, exp_we, i_busy, d_busy, finished;
    reg_adr_t   load_rd;
    int         i_wait, d_wait, n_issued;

    secv_core #(.IADR_WIDTH(IADR_WIDTH), .DADR_WIDTH(DADR_WIDTH)) dut0 (
        .clk_i(clk_i), .rst_i(rst_i),
        .imem_cyc_o(imem_cyc_o), .imem_stb_o(imem_stb_o), .imem_adr_o(imem_adr_o),
        .imem_dat_i(imem_dat_i), .imem_ack_i(imem_ack_i),
        .dmem_cyc_o(dmem_cyc_o), .dmem_stb_o(dmem_stb_o), .dmem_we_o(dmem_we_o),
        .dmem_adr_o(dmem_adr_o), .dmem_dat_o(dmem_dat_o),
        .dmem_dat_i(dmem_dat_i), .dmem_ack_i(dmem_ack_i)
    );

    bind secv_core secv_core_checker #(.IADR_WIDTH(IADR_WIDTH), .DADR_WIDTH(DADR_WIDTH)) chk0 (
        .clk_i(clk_i), .rst_i(rst_i),
        .imem_cyc_o(imem_cyc_o), .imem_stb_o(imem_stb_o), .imem_adr_o(imem_adr_o),
        .imem_ack_i(imem_ack_i), .dmem_cyc_o(dmem_cyc_o), .dmem_stb_o(dmem_stb_o),
        .dmem_adr_o(dmem_adr_o), .dmem_ack_i(dmem_ack_i)
    );

    task automatic stop_with_failure();
        $display("sim failed");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic value_error(string msg);
        $display("ERR %0t: %s", $time, msg);
        stop_with_failure();
    endtask

    task automatic report_failure(string msg);
        $display("%s", msg);
        stop_with_failure();
    endtask

    function automatic xlen_word_t sext12(logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

    // RV32I arithmetic, alt selects SUB or SRA
    function automatic xlen_word_t alu_ref(funct3_t f3, logic alt, xlen_word_t a, xlen_word_t b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: begin
                if (alt) begin
                    return $signed(a) >>> b[4:0];
                end
                return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_ref(funct3_t f3, xlen_word_t a, xlen_word_t b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic write_reg(reg_adr_t rd, xlen_word_t val);
        if (rd != '0) begin
            regs[rd] = val;
        end
    endtask

    task automatic expect_mem(logic we, xlen_word_t adr, xlen_word_t dat, reg_adr_t rd);
        mem_pending = 1'b1;
        exp_we      = we;
        exp_adr     = adr;
        exp_dat     = dat;
        load_rd     = rd;
    endtask

    // Random legal instruction, executed on the model as it is handed over
    task automatic issue_instr(output inst_t ins);
        int unsigned kind;
        logic [31:0] rnd;
        logic [12:0] boff;
        logic [20:0] joff;
        logic [11:0] imm12;
        reg_adr_t    rd, rs1, rs2;
        funct3_t     f3;
        logic        alt;
        xlen_word_t  a, b, next_pc;
        kind    = $urandom_range(0, 99);
        rnd     = $urandom;
        rd      = reg_adr_t'($urandom_range(0, 15));
        rs1     = reg_adr_t'($urandom_range(0, 15));
        rs2     = reg_adr_t'($urandom_range(0, 15));
        f3      = funct3_t'($urandom_range(0, 7));
        alt     = rnd[30];
        imm12   = rnd[31:20];
        boff    = {rnd[12:2], 2'b00};
        joff    = {rnd[20:2], 2'b00};
        a       = regs[rs1];
        b       = regs[rs2];
        next_pc = pc_ref + 32'd4;
        if (kind < 25) begin
            ins = {imm12[11:5], rs2, rs1, 3'b010, imm12[4:0], OPC_STORE};
            expect_mem(1'b1, a + sext12(imm12), b, rd);
        end else if (kind < 35) begin
            ins = {imm12, rs1, 3'b010, rd, OPC_LOAD};
            expect_mem(1'b0, a + sext12(imm12), b, rd);
        end else if (kind < 55) begin
            // funct7 bit only legal for ADD/SUB and SRL/SRA
            alt = alt && (f3 == 3'd0 || f3 == 3'd5);
            ins = {1'b0, alt, 5'b0, rs2, rs1, f3, rd, OPC_OP};
            write_reg(rd, alu_ref(f3, alt, a, b));
        end else if (kind < 75) begin
            if (f3 == 3'd1) begin
                imm12 = {7'b0, imm12[4:0]};
            end
            if (f3 == 3'd5) begin
                imm12 = {1'b0, alt, 5'b0, imm12[4:0]};
            end
            ins = {imm12, rs1, f3, rd, OPC_OP_IMM};
            write_reg(rd, alu_ref(f3, f3 == 3'd5 && alt, a, sext12(imm12)));
        end else if (kind < 80) begin
            ins = {rnd[31:12], rd, OPC_LUI};
            write_reg(rd, {rnd[31:12], 12'b0});
        end else if (kind < 84) begin
            ins = {rnd[31:12], rd, OPC_AUIPC};
            write_reg(rd, pc_ref + {rnd[31:12], 12'b0});
        end else if (kind < 92) begin
            // Codes 2 and 3 are not branches
            if (f3 == 3'd2 || f3 == 3'd3) begin
                f3 = f3 + 3'd2;
            end
            ins = {boff[12], boff[10:5], rs2, rs1, f3, boff[4:1], boff[11], OPC_BRANCH};
            if (branch_ref(f3, a, b)) begin
                next_pc = pc_ref + {{19{boff[12]}}, boff};
            end
        end else if (kind < 96) begin
            ins = {joff[20], joff[10:1], joff[11], joff[19:12], rd, OPC_JAL};
            write_reg(rd, next_pc);
            next_pc = pc_ref + {{11{joff[20]}}, joff};
        end else begin
            // Low immediate bits cancel rs1 misalignment
            imm12 = {rnd[11:2], 2'b00 - a[1:0]};
            ins = {imm12, rs1, 3'b000, rd, OPC_JALR};
            write_reg(rd, next_pc);
            next_pc = (a + sext12(imm12)) & ~32'd1;
        end
        pc_ref = next_pc;
    endtask

    // Instruction memory, random wait then a fresh instruction
    task automatic serve_imem();
        inst_t ins;
        if (imem_ack_i) begin
            imem_ack_i = 1'b0;
        end else if (imem_stb_o && !finished) begin
            if (!i_busy) begin
                i_busy = 1'b1;
                i_wait = $urandom_range(0, 3);
                assert (imem_adr_o == pc_ref[IADR_WIDTH-1:0])
                    else value_error($sformatf("fetch address %0h, expected %0h",
                                               imem_adr_o, pc_ref[IADR_WIDTH-1:0]));
                assert (!mem_pending)
                    else report_failure("Load or store finished without a data bus cycle");
                if (n_issued == N_INSTR) begin
                    finished = 1'b1;
                end
            end
            if (finished) begin
                i_busy = 1'b0;
            end else if (i_wait == 0) begin
                issue_instr(ins);
                imem_dat_i = ins;
                imem_ack_i = 1'b1;
                i_busy     = 1'b0;
                n_issued++;
            end else begin
                i_wait--;
            end
        end
    endtask

    // Data memory, random wait and random load data
    task automatic serve_dmem();
        if (dmem_ack_i) begin
            dmem_ack_i = 1'b0;
        end else if (dmem_stb_o) begin
            if (!d_busy) begin
                d_busy = 1'b1;
                d_wait = $urandom_range(0, 3);
                assert (mem_pending)
                    else report_failure("Data bus cycle for an instruction without memory access");
                assert (dmem_we_o == exp_we)
                    else value_error($sformatf("dmem_we_o %0b, expected %0b", dmem_we_o, exp_we));
                assert (dmem_adr_o == exp_adr[DADR_WIDTH-1:0])
                    else value_error($sformatf("data address %0h, expected %0h",
                                               dmem_adr_o, exp_adr[DADR_WIDTH-1:0]));
                if (exp_we) begin
                    assert (dmem_dat_o == exp_dat)
                        else value_error($sformatf("store data %08h, expected %08h",
                                                   dmem_dat_o, exp_dat));
                end
            end
            if (d_wait == 0) begin
                dmem_dat_i  = $urandom;
                dmem_ack_i  = 1'b1;
                d_busy      = 1'b0;
                mem_pending = 1'b0;
                if (!exp_we) begin
                    write_reg(load_rd, dmem_dat_i);
                end
            end else begin
                d_wait--;
            end
        end else begin
            assert (!dmem_we_o)
                else value_error("dmem_we_o high outside a bus cycle");
        end
    endtask

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired before all instructions completed");
        stop_with_failure();
    end

    initial begin
        void'($urandom(SEED));
        rst_i       = 1'b1;
        imem_ack_i  = 1'b0;
        imem_dat_i  = '0;
        dmem_ack_i  = 1'b0;
        dmem_dat_i  = '0;
        pc_ref      = '0;
        exp_adr     = '0;
        exp_dat     = '0;
        exp_we      = 1'b0;
        load_rd     = '0;
        mem_pending = 1'b0;
        i_busy      = 1'b0;
        d_busy      = 1'b0;
        finished    = 1'b0;
        i_wait      = 0;
        d_wait      = 0;
        n_issued    = 0;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        repeat (4) @(negedge clk_i);
        // Idle bus while in reset
        assert (!imem_cyc_o && !imem_stb_o && !dmem_cyc_o && !dmem_stb_o && !dmem_we_o)
            else value_error("bus outputs active during reset");
        rst_i = 1'b0;
        // Responders work on the falling edge
        fork
            forever begin
                @(negedge clk_i);
                serve_imem();
                serve_dmem();
                assert (dut0.chk0.fail_cnt == 0)
                    else report_failure("Bus protocol assertion failed");
            end
        join_none
        wait (finished);
        @(negedge clk_i);
        if (dut0.chk0.fail_cnt == 0) begin
            $display("sim passed");
            $finish;
        end else begin
            $display("sim failed");
            $fatal(1, "bus protocol assertions failed");
        end
    end
endmodule
